// File: all.f
rtl/daqPkg.sv
rtl/cmdDecoder.sv
rtl/scLoader.sv
rtl/sweepCtrl.sv
rtl/acqReadout.sv
rtl/fifoArbiter.sv
rtl/dataFifo.sv
rtl/daqTop.sv
tb/daqChecker.sv
tb/daqTb.sv

// File: run.sh
#!/bin/sh
# Build and run the DAQ testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module daqTb -f all.f -o daqSim

./obj_dir/daqSim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    exit 0
else
    exit 1
fi

// File: tb/daqTb.sv
`default_nettype none

module daqTb
    import daqPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 4000;   // Cycles per wait

    logic                Clk;
    logic                rstN;
    logic                cmdReq;
    cmdWord_u            cmdWord;
    logic                doutB;
    logic                transmitOnB;
    logic                trigInB;
    logic                rdEn;
    logic                cmdAck;
    scPins_t             scPins;
    logic                sweepBusy;
    logic                startReadout;
    dataWord_t           rdData;
    logic                empty;
    logic [HEADER_W-1:0] header;        // Model of the header register

    daqTop daqTop_i (.*);

    daqChecker daqChecker (.Clk, .rstN, .scPins, .rdEn, .rdData, .empty);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    initial begin
        #500000;
        $display("Simulation watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic tick(input int n = 1);
        repeat (n) @(posedge Clk);
        #1;                                 // Drive after the edge
    endtask

    function automatic logic level(input int sel);
        case (sel)
            0: return cmdAck;
            1: return scPins.select;
            2: return startReadout;
            3: return sweepBusy;
            default: return empty;
        endcase
    endfunction

    task automatic waitLevel(input int sel, input logic want, input string what);
        int cycles;
        cycles = 0;
        while (level(sel) !== want && cycles < WAIT_LIMIT) begin
            cycles++;
            tick();
        end
        if (level(sel) !== want) daqChecker.note({"timed out waiting for ", what});
    endtask

    task automatic sendCmd(input logic isAct, input logic [2:0] code, input logic [11:0] value);
        cmdWord = {isAct, code, value};
        cmdReq  = 1'b1;
        waitLevel(0, 1'b1, "command ack");
        cmdReq = 1'b0;
        waitLevel(0, 1'b0, "command ack release");
        tick();
    endtask

    task automatic writeReg(input logic [2:0] addr, input logic [11:0] value);
        sendCmd(1'b0, addr, value);
    endtask

    task automatic action(input logic [2:0] op);
        sendCmd(1'b1, op, 12'h0);
    endtask

    // ASIC word on doutB inverted and MSB first
    task automatic sendWord(input logic [DATA_W-1:0] data, input bit expectIt);
        if (expectIt) begin
            waitLevel(2, 1'b1, "startReadout");
            daqChecker.expectReadout(data);
        end
        for (int i = DATA_W - 1; i >= 0; i--) begin
            transmitOnB = 1'b0;
            doutB       = ~data[i];
            tick();
        end
        transmitOnB = 1'b1;
        doutB       = 1'b1;
        tick(3);
    endtask

    task automatic pulses(input int n);
        repeat (n) begin
            trigInB = 1'b0;
            tick(3);
            trigInB = 1'b1;
            tick(3);
        end
    endtask

    task automatic runSweep(input int s, input int e);
        writeReg(REG_START_DAC, 12'(s));
        writeReg(REG_END_DAC, 12'(e));
        for (int d = s; d <= e; d++) begin
            daqChecker.expectFrame({header, DAC_W'(d)});
            daqChecker.expectSweep(DATA_W'(d));
            daqChecker.expectSweep(DATA_W'(d % 8));
        end
        action(OP_SWEEP_START);
        for (int d = s; d <= e; d++) begin
            waitLevel(1, 1'b1, "sweep frame start");
            daqChecker.compare("sweepBusy in sweep", 1, sweepBusy);
            waitLevel(1, 1'b0, "sweep frame end");
            tick(20);
            pulses(d % 8);
        end
        waitLevel(3, 1'b0, "sweepBusy to fall");
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (daqChecker.pending() != 0 && cycles < WAIT_LIMIT) begin
            cycles++;
            tick();
        end
        if (daqChecker.pending() != 0) daqChecker.note("expected words never left the FIFO");
        tick(60);                            // Catch stray words
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        int s;
        logic [HEADER_W-1:0] h;
        logic [DAC_W-1:0] v;
        void'($urandom(32'h9a13));
        rstN        = 1'b0;
        cmdReq      = 1'b0;
        cmdWord     = '0;
        doutB       = 1'b1;
        transmitOnB = 1'b1;
        trigInB     = 1'b1;
        rdEn        = 1'b0;
        header      = '0;
        tick(3);
        rstN = 1'b1;
        tick(2);

        daqChecker.startTest("command handshake");
        repeat (20) begin
            if ($urandom_range(1) == 1) action(3'($urandom_range(7, 5)));   // Unknown ops
            else writeReg(3'($urandom_range(7, 3)), 12'($urandom));
        end
        daqChecker.endTest();

        daqChecker.startTest("slow-control load");
        repeat (3) begin
            h = HEADER_W'($urandom);
            v = DAC_W'($urandom);
            writeReg(REG_HEADER, 12'(h));
            header = h;
            writeReg(REG_DAC_VTH, 12'(v));
            daqChecker.expectFrame({h, v});
            action(OP_LOAD_SC);
            waitLevel(1, 1'b1, "select to rise");
            waitLevel(1, 1'b0, "select to fall");
            tick(4);
        end
        daqChecker.endTest();

        daqChecker.startTest("readout");
        rdEn = 1'b1;
        action(OP_ACQ_START);
        repeat (6) sendWord(DATA_W'($urandom), 1'b1);
        action(OP_ACQ_STOP);
        repeat (3) sendWord(DATA_W'($urandom), 1'b0);   // Must be dropped
        drain();
        daqChecker.endTest();

        daqChecker.startTest("sweep");
        writeReg(REG_WINDOW, 12'($urandom_range(140, 80)));
        s = $urandom_range(1000);
        runSweep(s, s + $urandom_range(3));
        drain();
        daqChecker.endTest();

        daqChecker.startTest("back-pressure");
        rdEn = 1'b0;
        action(OP_ACQ_START);
        s = $urandom_range(1000);
        fork
            runSweep(s, s + 2);
            repeat (20) sendWord(DATA_W'($urandom), 1'b1);
            begin
                tick(400);                  // Reader stalls while the FIFO fills
                rdEn = 1'b1;
            end
        join
        action(OP_ACQ_STOP);
        drain();
        daqChecker.endTest();

        daqChecker.startTest("fifo clear");
        rdEn = 1'b0;
        action(OP_ACQ_START);
        repeat (3) sendWord(DATA_W'($urandom), 1'b1);
        action(OP_ACQ_STOP);
        tick(40);
        daqChecker.compare("empty before clear", 0, empty);
        action(OP_FIFO_CLEAR);
        daqChecker.flush();
        daqChecker.compare("empty after clear", 1, empty);
        tick(20);
        daqChecker.endTest();

        daqChecker.summary();
        if (daqChecker.errCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/daqChecker.sv
`default_nettype none

module daqChecker
    import daqPkg::*;
(
    input logic      Clk,
    input logic      rstN,
    input scPins_t   scPins,
    input logic      rdEn,
    input dataWord_t rdData,
    input logic      empty
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [DATA_W-1:0]        acqExp[$];     // Expected readout payloads
    logic [DATA_W-1:0]        swExp[$];      // Expected sweep payloads
    scConfig_t                frameExp[$];
    string                    testName = "none";
    int                       errCount = 0;
    int                       testErrs = 0;
    int                       checkCount = 0;
    logic [SC_FRAME_BITS-1:0] bits;          // Collected srIn bits
    int                       nBits = 0;
    int                       rstLow = 0;    // Cycles of srRstb low in this frame
    logic                     prevCk = 1'b0;
    logic                     prevSel = 1'b0;

    //////////////////////////////
    // Bookkeeping
    //////////////////////////////
    task automatic startTest(input string name);
        testName = name;
        testErrs = 0;
    endtask

    task automatic note(input string msg);
        $display("Error in %s: %s", testName, msg);
        errCount++;
        testErrs++;
    endtask

    task automatic compare(input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        checkCount++;
        if (expVal !== actVal) begin
            $display("Fail %s %s: expected %h, actual %h", testName, what, expVal, actVal);
            errCount++;
            testErrs++;
        end
    endtask

    task automatic endTest();
        if (testErrs == 0) $display("Test %s: passed", testName);
        else $display("Test %s: %0d errors", testName, testErrs);
    endtask

    task automatic summary();
        $display("Checks %0d, errors %0d", checkCount, errCount);
    endtask

    task automatic expectReadout(input logic [DATA_W-1:0] w);
        acqExp.push_back(w);
    endtask

    task automatic expectSweep(input logic [DATA_W-1:0] w);
        swExp.push_back(w);
    endtask

    task automatic expectFrame(input scConfig_t f);
        frameExp.push_back(f);
    endtask

    task automatic flush();    // Nothing left to read after a clear
        acqExp.delete();
        swExp.delete();
    endtask

    function automatic int pending();
        return acqExp.size() + swExp.size() + frameExp.size();
    endfunction

    //////////////////////////////
    // Monitors
    //////////////////////////////
    always @(posedge Clk) begin
        if (!rstN) begin
            nBits   = 0;
            rstLow  = 0;
            prevCk  = 1'b0;
            prevSel = 1'b0;
        end else begin
            // Word leaves the FIFO on this edge
            if (rdEn && !empty) begin
                if (rdData.source) begin
                    if (swExp.size() == 0)
                        note($sformatf("unexpected sweep word %h", rdData.payload));
                    else
                        compare("sweep word", swExp.pop_front(), rdData.payload);
                end else begin
                    if (acqExp.size() == 0)
                        note($sformatf("unexpected readout word %h", rdData.payload));
                    else
                        compare("readout word", acqExp.pop_front(), rdData.payload);
                end
            end
            // Register reset pulse only ahead of the first bit
            if (!scPins.srRstb) begin
                if (scPins.select && nBits == 0) rstLow++;
                else note("srRstb went low outside the frame reset phase");
            end
            // srIn sampled on rising srCk
            if (scPins.select && scPins.srCk && !prevCk) begin
                bits = {bits[SC_FRAME_BITS-2:0], scPins.srIn};
                nBits++;
            end
            if (prevSel && !scPins.select) begin   // Frame ended
                if (frameExp.size() == 0) begin
                    note("a frame was shifted with none expected");
                end else begin
                    compare("frame length", SC_FRAME_BITS, nBits);
                    compare("srRstb low cycles", SC_BIT_CYCLES, rstLow);
                    compare("frame", frameExp.pop_front(), bits);
                end
                nBits  = 0;
                rstLow = 0;
            end
            prevCk  = scPins.srCk;
            prevSel = scPins.select;
        end
    end

endmodule

`default_nettype wire

// File: rtl/daqTop.sv
`default_nettype none

module daqTop
    import daqPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  logic      cmdReq,
    input  cmdWord_u  cmdWord,
    input  logic      doutB,
    input  logic      transmitOnB,
    input  logic      trigInB,
    input  logic      rdEn,
    output logic      cmdAck,
    output scPins_t   scPins,
    output logic      sweepBusy,
    output logic      startReadout,
    output dataWord_t rdData,
    output logic      empty
);

    //////////////////////////////
    // Internal nets
    //////////////////////////////
    scConfig_t hostCfg;
    sweepCfg_t sweepCfg;
    logic      loadPulse;
    logic      sweepPulse;
    logic      acqOn;
    logic      fifoClear;
    logic      loadReq;     // Sweep to loader
    logic      loadAck;
    scConfig_t frame;
    logic      acqReq;      // Readout peer
    logic      acqAck;
    dataWord_t acqWord;
    logic      swReq;       // Sweep peer
    logic      swAck;
    dataWord_t swWord;
    logic      wrEn;        // Arbiter to FIFO
    dataWord_t wrData;
    logic      full;

    cmdDecoder cmdDecoder_i (
        .Clk, .rstN, .cmdReq, .cmdWord, .cmdAck,
        .hostCfg, .sweepCfg, .loadPulse, .sweepPulse, .acqOn, .fifoClear
    );

    scLoader scLoader_i (
        .Clk, .rstN, .loadReq, .frame, .loadAck, .scPins
    );

    sweepCtrl sweepCtrl_i (
        .Clk, .rstN, .hostCfg, .sweepCfg, .loadPulse, .sweepPulse, .loadAck,
        .trigInB, .swAck, .loadReq, .frame, .sweepBusy, .swReq, .swWord
    );

    acqReadout acqReadout_i (
        .Clk, .rstN, .acqOn, .doutB, .transmitOnB, .acqAck,
        .startReadout, .acqReq, .acqWord
    );

    fifoArbiter fifoArbiter_i (
        .Clk, .rstN, .acqReq, .acqWord, .swReq, .swWord, .full,
        .acqAck, .swAck, .wrEn, .wrData
    );

    dataFifo dataFifo_i (
        .Clk, .rstN, .clear(fifoClear), .wrEn, .wrData, .rdEn,
        .full, .rdData, .empty
    );

endmodule

`default_nettype wire

// File: rtl/dataFifo.sv
`default_nettype none

module dataFifo
    import daqPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  logic      clear,
    input  logic      wrEn,
    input  dataWord_t wrData,
    input  logic      rdEn,
    output logic      full,
    output dataWord_t rdData,
    output logic      empty
);

    dataWord_t          mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wrPtr;
    logic [FIFO_AW-1:0] rdPtr;
    logic [FIFO_AW:0]   count;
    logic               doWrite;
    logic               doRead;

    assign full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign doWrite = wrEn && !full;
    assign doRead  = rdEn && !empty;
    assign rdData  = mem[rdPtr];   // Show-ahead

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) wrPtr <= wrPtr + 1'b1;
            if (doRead) rdPtr <= rdPtr + 1'b1;
            count <= count + (FIFO_AW+1)'(doWrite) - (FIFO_AW+1)'(doRead);
        end
    end

    always_ff @(posedge Clk) begin
        if (doWrite) mem[wrPtr] <= wrData;
    end

endmodule

`default_nettype wire

// File: rtl/fifoArbiter.sv
`default_nettype none

module fifoArbiter
    import daqPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  logic      acqReq,
    input  dataWord_t acqWord,
    input  logic      swReq,
    input  dataWord_t swWord,
    input  logic      full,
    output logic      acqAck,
    output logic      swAck,
    output logic      wrEn,
    output dataWord_t wrData
);

    logic lastSw;   // Last grant went to sweep
    logic acqPend;
    logic swPend;
    logic canWrite;
    logic pickAcq;
    logic pickSw;

    assign acqPend  = acqReq && !acqAck;
    assign swPend   = swReq && !swAck;
    assign canWrite = !full && !wrEn;   // Full not yet updated for a pending write
    assign pickAcq  = canWrite && acqPend && (!swPend || lastSw);
    assign pickSw   = canWrite && swPend && !pickAcq;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            lastSw <= 1'b0;
            acqAck <= 1'b0;
            swAck  <= 1'b0;
            wrEn   <= 1'b0;
        end else begin
            wrEn <= pickAcq || pickSw;  // Ack and write share a cycle
            if (pickAcq) begin
                acqAck <= 1'b1;
                lastSw <= 1'b0;
            end else if (acqAck && !acqReq) begin
                acqAck <= 1'b0;
            end
            if (pickSw) begin
                swAck  <= 1'b1;
                lastSw <= 1'b1;
            end else if (swAck && !swReq) begin
                swAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (pickAcq) wrData <= acqWord;
        else if (pickSw) wrData <= swWord;
    end

endmodule

`default_nettype wire

// File: rtl/acqReadout.sv
`default_nettype none

module acqReadout
    import daqPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  logic      acqOn,
    input  logic      doutB,
    input  logic      transmitOnB,
    input  logic      acqAck,
    output logic      startReadout,
    output logic      acqReq,
    output dataWord_t acqWord
);

    logic [1:0]                doutS;      // Two-stage synchronizers
    logic [1:0]                tonS;
    logic [$clog2(DATA_W)-1:0] bitCnt;
    logic [DATA_W-1:0]         shiftReg;
    logic [DATA_W-1:0]         newWord;
    logic                      shiftFull;  // Finished word parked in shifter
    logic                      ackWait;    // Waiting for ack to drop
    logic                      tonAct;
    logic                      wordDone;
    logic                      takeNew;
    logic                      holdFree;
    logic                      loadHold;

    assign tonAct   = ~tonS[1];
    assign newWord  = {shiftReg[DATA_W-2:0], ~doutS[1]};  // Bits arrive inverted
    assign wordDone = tonAct && !shiftFull && (bitCnt == '1);
    assign takeNew  = wordDone && acqOn;                  // Dropped while acq off
    assign holdFree = !acqReq && !ackWait;
    assign loadHold = holdFree && (takeNew || shiftFull);

    assign startReadout = acqOn && holdFree && !shiftFull;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            doutS     <= '1;
            tonS      <= '1;
            bitCnt    <= '0;
            shiftFull <= 1'b0;
            acqReq    <= 1'b0;
            ackWait   <= 1'b0;
        end else begin
            doutS <= {doutS[0], doutB};
            tonS  <= {tonS[0], transmitOnB};
            if (!tonAct) bitCnt <= '0;
            else if (!shiftFull) bitCnt <= bitCnt + 1'b1;
            // Four-phase toward arbiter
            if (acqReq && acqAck) begin
                acqReq  <= 1'b0;
                ackWait <= 1'b1;
            end else if (ackWait && !acqAck) begin
                ackWait <= 1'b0;
            end
            if (loadHold) acqReq <= 1'b1;
            if (loadHold) shiftFull <= 1'b0;
            else if (takeNew) shiftFull <= 1'b1;  // Holding register busy
        end
    end

    always_ff @(posedge Clk) begin
        if (tonAct && !shiftFull) shiftReg <= newWord;
        if (loadHold) begin
            acqWord.source  <= 1'b0;
            acqWord.payload <= shiftFull ? shiftReg : newWord;
        end
    end

endmodule

`default_nettype wire

// File: rtl/sweepCtrl.sv
`default_nettype none

module sweepCtrl
    import daqPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  scConfig_t hostCfg,
    input  sweepCfg_t sweepCfg,
    input  logic      loadPulse,
    input  logic      sweepPulse,
    input  logic      loadAck,
    input  logic      trigInB,
    input  logic      swAck,
    output logic      loadReq,
    output scConfig_t frame,
    output logic      sweepBusy,
    output logic      swReq,
    output dataWord_t swWord
);

    typedef enum logic [2:0] {
        SW_IDLE, SW_LOAD, SW_LDONE, SW_WIN, SW_WRDAC, SW_WRCNT
    } swState_e;

    swState_e            state;
    logic [DAC_W-1:0]    dac;       // Current step
    logic [DAC_W-1:0]    endQ;      // Sweep end, latched at start
    logic [WINDOW_W-1:0] windowQ;
    logic [WINDOW_W-1:0] winCnt;    // Cycles left in window
    logic [DATA_W-1:0]   trigCnt;   // Saturating trigger count
    logic [2:0]          trigS;     // Sync plus edge stage
    logic                trigFall;

    assign trigFall = trigS[2] & ~trigS[1];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state     <= SW_IDLE;
            loadReq   <= 1'b0;
            frame     <= '0;
            sweepBusy <= 1'b0;
            dac       <= '0;
            endQ      <= '0;
            windowQ   <= '0;
            winCnt    <= '0;
            trigCnt   <= '0;
            trigS     <= '1;
            swReq     <= 1'b0;
            swWord    <= '0;
        end else begin
            trigS <= {trigS[1:0], trigInB};
            case (state)
                //////////////////////////////
                // Start, host load or sweep
                //////////////////////////////
                SW_IDLE: begin
                    if (sweepPulse && sweepCfg.endDac >= sweepCfg.startDac) begin
                        frame.header <= hostCfg.header;
                        frame.dacVth <= sweepCfg.startDac;
                        dac          <= sweepCfg.startDac;
                        endQ         <= sweepCfg.endDac;
                        windowQ      <= sweepCfg.window;
                        sweepBusy    <= 1'b1;
                        loadReq      <= 1'b1;
                        state        <= SW_LOAD;
                    end else if (loadPulse) begin
                        frame   <= hostCfg;      // Plain forward
                        loadReq <= 1'b1;
                        state   <= SW_LOAD;
                    end
                end
                SW_LOAD: begin
                    if (loadAck) begin
                        loadReq <= 1'b0;
                        state   <= SW_LDONE;
                    end
                end
                SW_LDONE: begin                  // Wait ack low
                    if (!loadAck) begin
                        if (sweepBusy) begin
                            winCnt  <= windowQ;
                            trigCnt <= '0;
                            state   <= SW_WIN;
                        end else begin
                            state <= SW_IDLE;
                        end
                    end
                end
                //////////////////////////////
                // Count and report
                //////////////////////////////
                SW_WIN: begin
                    if (winCnt == '0) begin
                        swReq  <= 1'b1;
                        swWord <= '{source: 1'b1, payload: DATA_W'(dac)};
                        state  <= SW_WRDAC;
                    end else begin
                        winCnt <= winCnt - 1'b1;
                        if (trigFall && trigCnt != '1) trigCnt <= trigCnt + 1'b1;
                    end
                end
                SW_WRDAC: begin
                    if (swAck) begin
                        swReq <= 1'b0;
                    end else if (!swReq) begin   // Handshake closed
                        swReq  <= 1'b1;
                        swWord <= '{source: 1'b1, payload: trigCnt};
                        state  <= SW_WRCNT;
                    end
                end
                SW_WRCNT: begin
                    if (swAck) begin
                        swReq <= 1'b0;
                    end else if (!swReq) begin
                        if (dac == endQ) begin
                            sweepBusy <= 1'b0;   // Last step done
                            state     <= SW_IDLE;
                        end else begin
                            dac          <= dac + 1'b1;
                            frame.dacVth <= dac + 1'b1;
                            loadReq      <= 1'b1;
                            state        <= SW_LOAD;
                        end
                    end
                end
                default: state <= SW_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/scLoader.sv
`default_nettype none

module scLoader
    import daqPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  logic      loadReq,
    input  scConfig_t frame,
    output logic      loadAck,
    output scPins_t   scPins
);

    typedef enum logic [1:0] {SC_IDLE, SC_RESET, SC_SHIFT, SC_ACK} scState_e;

    scState_e                 state;
    logic [SC_DIV_W-1:0]      div;       // Position inside a bit time
    logic [SC_CNT_W-1:0]      bitCnt;
    logic [SC_FRAME_BITS-1:0] shiftReg;  // Latched frame, MSB on srIn
    logic                     bitEnd;

    assign bitEnd = (div == SC_DIV_W'(SC_BIT_CYCLES - 1));

    // Pins decoded from state
    always_comb begin
        scPins.select = (state == SC_RESET) || (state == SC_SHIFT);
        scPins.srRstb = (state != SC_RESET);  // Low for one bit time
        scPins.srCk   = (state == SC_SHIFT) && (div >= SC_DIV_W'(SC_BIT_CYCLES / 2));
        scPins.srIn   = (state == SC_SHIFT) && shiftReg[SC_FRAME_BITS-1];
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state   <= SC_IDLE;
            div     <= '0;
            bitCnt  <= '0;
            loadAck <= 1'b0;
        end else begin
            case (state)
                SC_IDLE: begin
                    if (loadReq) begin
                        div   <= '0;
                        state <= SC_RESET;
                    end
                end
                SC_RESET: begin
                    div <= div + 1'b1;
                    if (bitEnd) begin
                        bitCnt <= '0;
                        state  <= SC_SHIFT;
                    end
                end
                SC_SHIFT: begin
                    div <= div + 1'b1;  // Wraps at bit end
                    if (bitEnd) begin
                        if (bitCnt == SC_CNT_W'(SC_FRAME_BITS - 1)) state <= SC_ACK;
                        else bitCnt <= bitCnt + 1'b1;
                    end
                end
                SC_ACK: begin
                    if (!loadAck) begin
                        loadAck <= 1'b1;            // One cycle after select falls
                    end else if (!loadReq) begin
                        loadAck <= 1'b0;
                        state   <= SC_IDLE;
                    end
                end
                default: state <= SC_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == SC_IDLE && loadReq) shiftReg <= frame;
        else if (state == SC_SHIFT && bitEnd) shiftReg <= shiftReg << 1;
    end

endmodule

`default_nettype wire

// File: rtl/cmdDecoder.sv
`default_nettype none

module cmdDecoder
    import daqPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  logic      cmdReq,
    input  cmdWord_u  cmdWord,
    output logic      cmdAck,
    output scConfig_t hostCfg,
    output sweepCfg_t sweepCfg,
    output logic      loadPulse,
    output logic      sweepPulse,
    output logic      acqOn,
    output logic      fifoClear
);

    logic reqQ;     // Registered host request
    logic execute;  // First cycle of a new request

    assign execute = reqQ & ~cmdAck;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            reqQ       <= 1'b0;
            cmdAck     <= 1'b0;
            hostCfg    <= '0;
            sweepCfg   <= '0;
            loadPulse  <= 1'b0;
            sweepPulse <= 1'b0;
            acqOn      <= 1'b0;
            fifoClear  <= 1'b0;
        end else begin
            reqQ       <= cmdReq;
            cmdAck     <= reqQ;    // Ack follows req by two cycles both ways
            loadPulse  <= 1'b0;
            sweepPulse <= 1'b0;
            fifoClear  <= 1'b0;
            if (execute) begin
                if (cmdWord.action.isAction) begin
                    case (cmdWord.action.opcode)
                        OP_LOAD_SC:     loadPulse  <= 1'b1;
                        OP_ACQ_START:   acqOn      <= 1'b1;
                        OP_ACQ_STOP:    acqOn      <= 1'b0;
                        OP_SWEEP_START: sweepPulse <= 1'b1;
                        OP_FIFO_CLEAR:  fifoClear  <= 1'b1;
                        default: ;      // Unknown opcode, ack only
                    endcase
                end else begin
                    // Low bits of the value go to the addressed field
                    case (cmdWord.regWrite.addr)
                        REG_DAC_VTH:   hostCfg.dacVth    <= cmdWord.regWrite.value[DAC_W-1:0];
                        REG_START_DAC: sweepCfg.startDac <= cmdWord.regWrite.value[DAC_W-1:0];
                        REG_END_DAC:   sweepCfg.endDac   <= cmdWord.regWrite.value[DAC_W-1:0];
                        REG_WINDOW:    sweepCfg.window   <= cmdWord.regWrite.value[WINDOW_W-1:0];
                        REG_HEADER:    hostCfg.header    <= cmdWord.regWrite.value[HEADER_W-1:0];
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/daqPkg.sv
`default_nettype none

package daqPkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////
    localparam int DAC_W         = 10;   // Threshold DAC
    localparam int HEADER_W      = 8;    // ASIC header
    localparam int WINDOW_W      = 12;   // Trigger window length
    localparam int DATA_W        = 16;   // Readout word payload
    localparam int FIFO_DEPTH    = 16;
    localparam int FIFO_AW       = $clog2(FIFO_DEPTH);
    localparam int SC_BIT_CYCLES = 4;    // Clk cycles per select-register bit
    localparam int SC_DIV_W      = $clog2(SC_BIT_CYCLES);
    localparam int SC_FRAME_BITS = HEADER_W + DAC_W;
    localparam int SC_CNT_W      = $clog2(SC_FRAME_BITS);

    // Host register map
    localparam logic [2:0] REG_DAC_VTH   = 3'd0;
    localparam logic [2:0] REG_START_DAC = 3'd1;
    localparam logic [2:0] REG_END_DAC   = 3'd2;
    localparam logic [2:0] REG_WINDOW    = 3'd3;
    localparam logic [2:0] REG_HEADER    = 3'd4;

    // Host actions
    localparam logic [2:0] OP_LOAD_SC     = 3'd0;
    localparam logic [2:0] OP_ACQ_START   = 3'd1;
    localparam logic [2:0] OP_ACQ_STOP    = 3'd2;
    localparam logic [2:0] OP_SWEEP_START = 3'd3;
    localparam logic [2:0] OP_FIFO_CLEAR  = 3'd4;

    //////////////////////////////
    // Types
    //////////////////////////////
    // Host word, tag bit selects the view
    typedef union packed {
        struct packed {
            logic        isAction;   // 0 here
            logic [2:0]  addr;
            logic [11:0] value;
        } regWrite;
        struct packed {
            logic        isAction;   // 1 here
            logic [2:0]  opcode;
            logic [11:0] unused;
        } action;
    } cmdWord_u;

    typedef struct packed {
        logic [HEADER_W-1:0] header;  // Shifted out first
        logic [DAC_W-1:0]    dacVth;
    } scConfig_t;

    typedef struct packed {
        logic select;
        logic srRstb;
        logic srCk;
        logic srIn;
    } scPins_t;

    typedef struct packed {
        logic              source;   // 0 readout, 1 sweep
        logic [DATA_W-1:0] payload;
    } dataWord_t;

    typedef struct packed {
        logic [DAC_W-1:0]    startDac;
        logic [DAC_W-1:0]    endDac;
        logic [WINDOW_W-1:0] window;
    } sweepCfg_t;

endpackage

`default_nettype wire
